/* project.f */
common/fetch_pkg.sv
src/fetch_csr.sv
mmu/itlb.sv
mmu/addr_translate.sv
ifetch/pre_if_stage.sv
ifetch/if_stage.sv
src/fetch_top.sv
bench/fetch_sva.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front

sources:
  - common/fetch_pkg.sv
  - src/fetch_csr.sv
  - mmu/itlb.sv
  - mmu/addr_translate.sv
  - ifetch/pre_if_stage.sv
  - ifetch/if_stage.sv
  - src/fetch_top.sv
  - target: test
    files:
      - bench/fetch_sva.sv
      - bench/fetch_tb.sv

/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam logic [31:0] RESET_PC    = 32'h1c000000;
    localparam int          TLB_ENTRIES = 16;
    localparam int          WAIT_LIMIT  = 200;
    localparam logic [31:0] WORD_KEY    = 32'hdeadbeef;

    logic                           clk;
    logic                           reset;
    logic                           br_taken;
    logic [31:0]                    br_target;
    logic                           flush;
    logic [31:0]                    flush_target;
    logic                           csr_we;
    csr_num_e                       csr_num;
    logic [31:0]                    csr_wdata;
    logic                           tlb_we;
    logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex;
    logic [19:0]                    tlb_wvppn;
    logic [5:0]                     tlb_wps;
    logic [19:0]                    tlb_wppn;
    logic [1:0]                     tlb_wplv;
    logic                           tlb_wv;
    logic                           inst_sram_req;
    logic [31:0]                    inst_sram_addr;
    logic                           inst_sram_addr_ok;
    logic                           inst_sram_data_ok;
    logic [31:0]                    inst_sram_rdata;
    logic                           inst_valid;
    logic                           inst_ready;
    logic [31:0]                    inst_pc;
    logic [31:0]                    inst_word;
    fetch_exc_e                     inst_exc;

    integer      seed;
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        rand_ready;

    // values sampled at the falling edge
    logic        reset_seen;
    logic        rand_seen;
    logic        acc_seen;
    logic        hold_seen;
    logic [31:0] acc_addr;

    int unsigned gap;
    logic [31:0] rsp_addr[$];
    int unsigned rsp_wait[$];
    logic [31:0] got_pc[$];
    logic [31:0] got_word[$];
    fetch_exc_e  got_exc[$];

    fetch_top #(
        .RESET_PC(RESET_PC),
        .TLB_ENTRIES(TLB_ENTRIES)
    ) dut0 (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        reset_seen = reset;
        rand_seen  = rand_ready;
        acc_seen   = !reset && inst_sram_req && inst_sram_addr_ok;
        hold_seen  = !reset && inst_sram_req && !inst_sram_addr_ok;
        acc_addr   = inst_sram_addr;
        // an instruction taken in a flush cycle is squashed by decode
        if (!reset && inst_valid && inst_ready && !flush) begin
            got_pc.push_back(inst_pc);
            got_word.push_back(inst_word);
            got_exc.push_back(inst_exc);
        end
    end

    // instruction memory, in-order responses with random delays
    always @(posedge clk) begin
        #2;
        if (reset_seen) begin
            gap = 0;
            rsp_addr.delete();
            rsp_wait.delete();
            inst_sram_addr_ok = 1'b0;
            inst_sram_data_ok = 1'b0;
            inst_ready = 1'b0;
        end else begin
            if (acc_seen) begin
                rsp_addr.push_back(acc_addr);
                rsp_wait.push_back(1 + $unsigned($random(seed)) % 3);
                gap = $unsigned($random(seed)) % 3;
            end else if (hold_seen && gap > 0) begin
                gap = gap - 1;
            end
            inst_sram_addr_ok = (gap == 0);
            foreach (rsp_wait[i]) begin
                if (rsp_wait[i] > 0) begin
                    rsp_wait[i] = rsp_wait[i] - 1;
                end
            end
            if (rsp_wait.size() > 0 && rsp_wait[0] == 0) begin
                inst_sram_data_ok = 1'b1;
                inst_sram_rdata = rsp_addr.pop_front() ^ WORD_KEY;
                void'(rsp_wait.pop_front());
            end else begin
                inst_sram_data_ok = 1'b0;
            end
            inst_ready = rand_seen ? (($random(seed) & 3) != 0) : 1'b1;
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic pop_inst(output logic [31:0] pc, output logic [31:0] word,
                            output fetch_exc_e exc, output bit ok);
        int n;
        n = 0;
        while (got_pc.size() == 0 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (got_pc.size() == 0) begin
            $display("timeout: no instruction delivered within %0d cycles", WAIT_LIMIT);
            errors++;
            ok = 1'b0;
            pc = '0;
            word = '0;
            exc = EXC_NONE;
        end else begin
            ok = 1'b1;
            pc = got_pc.pop_front();
            word = got_word.pop_front();
            exc = got_exc.pop_front();
        end
    endtask

    task automatic expect_inst(input logic [31:0] pc, input fetch_exc_e exc,
                               input logic [31:0] paddr);
        logic [31:0] got_p;
        logic [31:0] got_w;
        fetch_exc_e  got_e;
        bit          ok;
        pop_inst(got_p, got_w, got_e, ok);
        if (ok) begin
            if (got_p !== pc) begin
                $display("ERROR inst_pc got %h expected %h", got_p, pc);
                errors++;
            end
            if (got_e !== exc) begin
                $display("ERROR inst_exc got %h expected %h at pc %h", got_e, exc, pc);
                errors++;
            end
            // the word only counts when the fetch had no exception
            if (exc == EXC_NONE && got_w !== (paddr ^ WORD_KEY)) begin
                $display("ERROR inst_word got %h expected %h", got_w, paddr ^ WORD_KEY);
                errors++;
            end
        end
    endtask

    task automatic redirect(input logic [31:0] target);
        flush = 1'b1;
        flush_target = target;
        got_pc.delete();
        got_word.delete();
        got_exc.delete();
        tick();
        flush = 1'b0;
    endtask

    task automatic write_csr(input csr_num_e num, input logic [31:0] data);
        csr_we = 1'b1;
        csr_num = num;
        csr_wdata = data;
        tick();
        csr_we = 1'b0;
    endtask

    task automatic write_tlb(input logic [$clog2(TLB_ENTRIES)-1:0] idx, input logic [19:0] vppn,
                             input logic [5:0] ps, input logic [19:0] ppn,
                             input logic [1:0] plv, input logic v);
        tlb_we = 1'b1;
        tlb_windex = idx;
        tlb_wvppn = vppn;
        tlb_wps = ps;
        tlb_wppn = ppn;
        tlb_wplv = plv;
        tlb_wv = v;
        tick();
        tlb_we = 1'b0;
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic sequential_fetch();
        int          start;
        logic [31:0] pc;
        start = errors;
        for (int i = 0; i < 16; i++) begin
            // second half runs with decode stalling at random
            if (i == 8) begin
                rand_ready = 1'b1;
            end
            pc = RESET_PC + 32'(4 * i);
            expect_inst(pc, EXC_NONE, pc);
        end
        rand_ready = 1'b0;
        end_test("sequential da", start);
    endtask

    task automatic branch_redirect();
        int          start;
        int          n;
        bit          ok;
        bit          found;
        logic [31:0] p;
        logic [31:0] w;
        fetch_exc_e  e;
        logic [31:0] prev;
        logic [31:0] target;
        start = errors;
        target = 32'h1c002000;
        redirect(32'h1c001000);
        expect_inst(32'h1c001000, EXC_NONE, 32'h1c001000);
        br_taken = 1'b1;
        br_target = target;
        tick();
        br_taken = 1'b0;
        prev = 32'h1c001000;
        found = 1'b0;
        n = 0;
        while (!found && n < 8) begin
            pop_inst(p, w, e, ok);
            if (!ok) begin
                n = 8;
            end else if (p === target) begin
                found = 1'b1;
            end else if (p !== prev + 32'd4) begin
                $display("ERROR inst_pc got %h expected %h", p, prev + 32'd4);
                errors++;
                n = 8;
            end else begin
                prev = p;
                n++;
            end
        end
        if (!found) begin
            $display("branch target %h was never delivered", target);
            errors++;
        end else begin
            if (e !== EXC_NONE) begin
                $display("ERROR inst_exc got %h expected %h at pc %h", e, EXC_NONE, target);
                errors++;
            end
            if (w !== (target ^ WORD_KEY)) begin
                $display("ERROR inst_word got %h expected %h", w, target ^ WORD_KEY);
                errors++;
            end
        end
        expect_inst(target + 32'd4, EXC_NONE, target + 32'd4);
        expect_inst(target + 32'd8, EXC_NONE, target + 32'd8);
        end_test("branch", start);
    endtask

    task automatic flush_discard();
        int          start;
        int          n;
        bit          want_hold;
        logic [31:0] target;
        start = errors;
        for (int i = 0; i < 4; i++) begin
            target = 32'h1c004000 + 32'(i * 32'h100);
            // even rounds hit an accepted request, odd rounds one still waiting
            want_hold = i % 2;
            n = 0;
            while (!(want_hold ? hold_seen : acc_seen) && n < WAIT_LIMIT) begin
                tick();
                n++;
            end
            if (n == WAIT_LIMIT) begin
                $display("timeout: no outstanding request to flush");
                errors++;
            end
            redirect(target);
            expect_inst(target, EXC_NONE, target);
            expect_inst(target + 32'd4, EXC_NONE, target + 32'd4);
        end
        end_test("flush", start);
    endtask

    task automatic dmw_window();
        int start;
        start = errors;
        // vseg 3, pseg 1, kernel only
        write_csr(CSR_DMW0, 32'h62000001);
        write_csr(CSR_CRMD, 32'h00000010);
        redirect(32'h60001000);
        // top three bits become pseg 1
        expect_inst(32'h60001000, EXC_NONE, 32'h20001000);
        expect_inst(32'h60001004, EXC_NONE, 32'h20001004);
        write_csr(CSR_CRMD, 32'h00000013);
        redirect(32'h60001000);
        expect_inst(32'h60001000, EXC_TLBR, 32'h0);
        end_test("dmw window", start);
    endtask

    task automatic tlb_pages();
        int start;
        start = errors;
        write_csr(CSR_DMW0, 32'h00000000);
        write_csr(CSR_CRMD, 32'h00000010);
        write_tlb(0, 20'h00400, PAGE_SHIFT_4K, 20'h12345, PLV_USER, 1'b1);
        write_tlb(1, 20'h08000, PAGE_SHIFT_4M, 20'h2a400, PLV_USER, 1'b1);
        write_tlb(2, 20'h00500, PAGE_SHIFT_4K, 20'h00777, PLV_USER, 1'b0);
        write_tlb(3, 20'h00600, PAGE_SHIFT_4K, 20'h00888, PLV_KERNEL, 1'b1);
        // runs off the end of the 4K page into nothing
        redirect(32'h00400ff8);
        expect_inst(32'h00400ff8, EXC_NONE, 32'h12345ff8);
        expect_inst(32'h00400ffc, EXC_NONE, 32'h12345ffc);
        expect_inst(32'h00401000, EXC_TLBR, 32'h0);
        // 4M frame base is 2a400000
        redirect(32'h08123450);
        expect_inst(32'h08123450, EXC_NONE, 32'h2a523450);
        expect_inst(32'h08123454, EXC_NONE, 32'h2a523454);
        redirect(32'h00700000);
        expect_inst(32'h00700000, EXC_TLBR, 32'h0);
        redirect(32'h00500000);
        expect_inst(32'h00500000, EXC_PIF, 32'h0);
        write_csr(CSR_CRMD, 32'h00000013);
        redirect(32'h00600000);
        expect_inst(32'h00600000, EXC_PPI, 32'h0);
        redirect(32'h00400000);
        expect_inst(32'h00400000, EXC_NONE, 32'h12345000);
        end_test("tlb", start);
    endtask

    task automatic address_errors();
        int start;
        start = errors;
        // still user level from the tlb test
        redirect(32'h00400002);
        expect_inst(32'h00400002, EXC_ADEF, 32'h0);
        redirect(32'h80000000);
        expect_inst(32'h80000000, EXC_ADEF, 32'h0);
        write_csr(CSR_CRMD, 32'h00000010);
        redirect(32'h08123451);
        expect_inst(32'h08123451, EXC_ADEF, 32'h0);
        end_test("address error", start);
    endtask

    initial begin
        seed = 32'h52a36dd2;
        clk = 1'b0;
        reset = 1'b1;
        br_taken = 1'b0;
        br_target = '0;
        flush = 1'b0;
        flush_target = '0;
        csr_we = 1'b0;
        csr_num = CSR_CRMD;
        csr_wdata = '0;
        tlb_we = 1'b0;
        tlb_windex = '0;
        tlb_wvppn = '0;
        tlb_wps = '0;
        tlb_wppn = '0;
        tlb_wplv = '0;
        tlb_wv = 1'b0;
        inst_sram_addr_ok = 1'b0;
        inst_sram_data_ok = 1'b0;
        inst_sram_rdata = '0;
        inst_ready = 1'b0;
        rand_ready = 1'b0;
        reset_seen = 1'b1;
        rand_seen = 1'b0;
        acc_seen = 1'b0;
        hold_seen = 1'b0;
        acc_addr = '0;
        gap = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        sequential_fetch();
        branch_redirect();
        flush_discard();
        dmw_window();
        tlb_pages();
        address_errors();
        $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut0.sva0.fail_count);
        if (errors == 0 && dut0.sva0.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* bench/fetch_sva.sv */
`timescale 1ns/1ps

module fetch_sva
    import fetch_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        flush,
    input logic        inst_sram_req,
    input logic [31:0] inst_sram_addr,
    input logic        inst_sram_addr_ok,
    input logic        inst_valid,
    input logic        inst_ready,
    input logic [31:0] inst_pc,
    input logic [31:0] inst_word,
    input fetch_exc_e  inst_exc
);

    int fail_count = 0;

    // quiet outputs once a reset edge has been seen
    reset_quiet_a: assert property (@(posedge clk)
        reset |=> !inst_sram_req && !inst_valid)
        else begin
            $error("inst_sram_req or inst_valid high during reset");
            fail_count++;
        end

    req_hold_a: assert property (@(posedge clk) disable iff (reset)
        inst_sram_req && !inst_sram_addr_ok |=> inst_sram_req && $stable(inst_sram_addr))
        else begin
            $error("instruction request dropped or changed before addr_ok");
            fail_count++;
        end

    // a flush may drop the held instruction
    valid_hold_a: assert property (@(posedge clk) disable iff (reset)
        inst_valid && !inst_ready && !flush |=>
            inst_valid && $stable(inst_pc) && $stable(inst_word) && $stable(inst_exc))
        else begin
            $error("decode output changed while inst_ready was low");
            fail_count++;
        end

endmodule

bind fetch_top fetch_sva sva0 (.*);

/* src/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC    = 32'h1c000000,
    parameter int          TLB_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           br_taken,
    input  logic [31:0]                    br_target,
    input  logic                           flush,
    input  logic [31:0]                    flush_target,
    input  logic                           csr_we,
    input  csr_num_e                       csr_num,
    input  logic [31:0]                    csr_wdata,
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input  logic [19:0]                    tlb_wvppn,
    input  logic [5:0]                     tlb_wps,
    input  logic [19:0]                    tlb_wppn,
    input  logic [1:0]                     tlb_wplv,
    input  logic                           tlb_wv,
    output logic                           inst_sram_req,
    output logic [31:0]                    inst_sram_addr,
    input  logic                           inst_sram_addr_ok,
    input  logic                           inst_sram_data_ok,
    input  logic [31:0]                    inst_sram_rdata,
    output logic                           inst_valid,
    input  logic                           inst_ready,
    output logic [31:0]                    inst_pc,
    output logic [31:0]                    inst_word,
    output fetch_exc_e                     inst_exc
);

    // configuration into the translator
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_plv;
    logic        dmw0_plv0;
    logic        dmw0_plv3;
    logic        dmw1_plv0;
    logic        dmw1_plv3;
    logic [2:0]  dmw0_vseg;
    logic [2:0]  dmw0_pseg;
    logic [2:0]  dmw1_vseg;
    logic [2:0]  dmw1_pseg;

    // itlb search port
    logic [19:0] s_va;
    logic        s_found;
    logic [19:0] s_ppn;
    logic [5:0]  s_ps;
    logic [1:0]  s_plv;
    logic        s_v;

    logic [31:0] va;
    logic [31:0] paddr;
    fetch_exc_e  exc;

    logic        fs_allowin;
    logic        pfs_to_fs_valid;
    logic        pfs_to_fs_cancel;
    logic [31:0] pfs_to_fs_pc;
    fetch_exc_e  pfs_to_fs_exc;

    fetch_csr u_csr (.*);

    itlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) u_itlb (.*);

    addr_translate u_xlate (.*);

    pre_if_stage #(
        .RESET_PC(RESET_PC)
    ) u_pfs (.*);

    if_stage u_fs (.*);

endmodule

/* ifetch/if_stage.sv */
`timescale 1ns/1ps

module if_stage
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  logic        pfs_to_fs_valid,
    input  logic        pfs_to_fs_cancel,
    input  logic [31:0] pfs_to_fs_pc,
    input  fetch_exc_e  pfs_to_fs_exc,
    output logic        fs_allowin,
    input  logic        inst_sram_data_ok,
    input  logic [31:0] inst_sram_rdata,
    output logic        inst_valid,
    input  logic        inst_ready,
    output logic [31:0] inst_pc,
    output logic [31:0] inst_word,
    output fetch_exc_e  inst_exc
);

    logic        req_out;
    logic [31:0] req_pc;
    fetch_exc_e  req_exc;
    logic [2:0]  discard_cnt;
    logic [2:0]  discard_nxt;
    logic        resp_ok;
    logic        keep_req;
    logic        take;

    assign take       = inst_valid && inst_ready;
    assign fs_allowin = (!req_out && !inst_valid) || take;
    // responses are in order, dropped ones are always older
    assign resp_ok    = inst_sram_data_ok && discard_cnt == 3'd0;
    assign keep_req   = pfs_to_fs_valid && !pfs_to_fs_cancel;

    always_comb begin
        discard_nxt = discard_cnt;
        if (inst_sram_data_ok && discard_cnt != 3'd0) begin
            discard_nxt = discard_nxt - 3'd1;
        end
        if (pfs_to_fs_valid && pfs_to_fs_cancel) begin
            discard_nxt = discard_nxt + 3'd1;
        end
        // tracked request still in flight when the flush hits
        if (flush && req_out && !resp_ok) begin
            discard_nxt = discard_nxt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            discard_cnt <= 3'd0;
            req_out     <= 1'b0;
            inst_valid  <= 1'b0;
        end else begin
            discard_cnt <= discard_nxt;
            if (flush) begin
                req_out <= 1'b0;
            end else if (keep_req) begin
                req_out <= 1'b1;
            end else if (resp_ok) begin
                req_out <= 1'b0;
            end
            if (flush) begin
                inst_valid <= 1'b0;
            end else if (resp_ok) begin
                inst_valid <= 1'b1;
            end else if (take) begin
                inst_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep_req) begin
            req_pc  <= pfs_to_fs_pc;
            req_exc <= pfs_to_fs_exc;
        end
        if (resp_ok) begin
            inst_pc   <= req_pc;
            inst_word <= inst_sram_rdata;
            inst_exc  <= req_exc;
        end
    end

endmodule

/* ifetch/pre_if_stage.sv */
`timescale 1ns/1ps

module pre_if_stage
    import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC = 32'h1c000000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        br_taken,
    input  logic [31:0] br_target,
    input  logic        flush,
    input  logic [31:0] flush_target,
    input  logic        fs_allowin,
    output logic        inst_sram_req,
    output logic [31:0] inst_sram_addr,
    input  logic        inst_sram_addr_ok,
    output logic        pfs_to_fs_valid,
    output logic        pfs_to_fs_cancel,
    output logic [31:0] pfs_to_fs_pc,
    output fetch_exc_e  pfs_to_fs_exc,
    output logic [31:0] va,
    input  logic [31:0] paddr,
    input  fetch_exc_e  exc
);

    logic        pfs_valid;
    logic [31:0] pc;
    logic [31:0] seq_pc;
    logic [31:0] nextpc;

    logic        flush_r;
    logic [31:0] flush_target_r;
    logic        br_r;
    logic [31:0] br_target_r;

    // request raised last cycle and still waiting for addr_ok
    logic        req_hold;
    logic        hold_stale;
    logic [31:0] hold_pc;
    logic [31:0] hold_paddr;
    fetch_exc_e  hold_exc;

    logic        fresh_req;
    logic        accept;

    always_ff @(posedge clk) begin
        if (reset) begin
            pfs_valid <= 1'b0;
        end else begin
            pfs_valid <= 1'b1;
        end
    end

    assign seq_pc = pc + 32'd4;
    // a live flush suppresses the new request, so only its held copy matters
    assign nextpc = flush_r  ? flush_target_r :
                    br_r     ? br_target_r    :
                    br_taken ? br_target      :
                               seq_pc;
    assign va = nextpc;

    assign inst_sram_req  = pfs_valid && (req_hold || (fs_allowin && !flush));
    assign inst_sram_addr = req_hold ? hold_paddr : paddr;
    assign fresh_req      = inst_sram_req && !req_hold;
    assign accept         = inst_sram_req && inst_sram_addr_ok;

    assign pfs_to_fs_valid = accept;
    assign pfs_to_fs_pc    = req_hold ? hold_pc : nextpc;
    assign pfs_to_fs_exc   = req_hold ? hold_exc : exc;
    // held address already went stale under a flush
    assign pfs_to_fs_cancel = req_hold && (hold_stale || flush);

    always_ff @(posedge clk) begin
        if (reset) begin
            req_hold   <= 1'b0;
            hold_stale <= 1'b0;
        end else begin
            req_hold   <= inst_sram_req && !inst_sram_addr_ok;
            hold_stale <= pfs_to_fs_cancel && !accept;
        end
    end

    always_ff @(posedge clk) begin
        if (fresh_req) begin
            hold_pc    <= nextpc;
            hold_paddr <= paddr;
            hold_exc   <= exc;
        end
    end

    // redirects wait here until a new request picks them up
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_r <= 1'b0;
            br_r    <= 1'b0;
        end else begin
            if (flush) begin
                flush_r <= 1'b1;
            end else if (fresh_req) begin
                flush_r <= 1'b0;
            end
            if (flush || fresh_req) begin
                br_r <= 1'b0;
            end else if (br_taken) begin
                br_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flush) begin
            flush_target_r <= flush_target;
        end
        if (br_taken) begin
            br_target_r <= br_target;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC - 32'd4;
        end else if (accept) begin
            pc <= pfs_to_fs_pc;
        end
    end

endmodule

/* mmu/addr_translate.sv */
`timescale 1ns/1ps

module addr_translate
    import fetch_pkg::*;
(
    input  logic [31:0] va,
    input  logic        crmd_da,
    input  logic        crmd_pg,
    input  logic [1:0]  crmd_plv,
    input  logic        dmw0_plv0,
    input  logic        dmw0_plv3,
    input  logic        dmw1_plv0,
    input  logic        dmw1_plv3,
    input  logic [2:0]  dmw0_vseg,
    input  logic [2:0]  dmw0_pseg,
    input  logic [2:0]  dmw1_vseg,
    input  logic [2:0]  dmw1_pseg,
    output logic [19:0] s_va,
    input  logic        s_found,
    input  logic [19:0] s_ppn,
    input  logic [5:0]  s_ps,
    input  logic [1:0]  s_plv,
    input  logic        s_v,
    output logic [31:0] paddr,
    output fetch_exc_e  exc
);

    logic        da_mode;
    logic        dmw0_hit;
    logic        dmw1_hit;
    logic        tlb_path;
    logic        adef;
    logic [31:0] tlb_paddr;

    assign da_mode  = crmd_da && !crmd_pg;
    assign dmw0_hit = va[31:29] == dmw0_vseg &&
                      ((crmd_plv == PLV_KERNEL && dmw0_plv0) ||
                       (crmd_plv == PLV_USER && dmw0_plv3));
    assign dmw1_hit = va[31:29] == dmw1_vseg &&
                      ((crmd_plv == PLV_KERNEL && dmw1_plv0) ||
                       (crmd_plv == PLV_USER && dmw1_plv3));
    assign tlb_path = !da_mode && !dmw0_hit && !dmw1_hit;

    assign s_va      = va[31:12];
    assign tlb_paddr = (s_ps == PAGE_SHIFT_4M) ? {s_ppn[19:10], va[21:0]} :
                                                 {s_ppn, va[11:0]};

    always_comb begin
        if (da_mode) begin
            paddr = va;
        end else if (dmw0_hit) begin
            paddr = {dmw0_pseg, va[28:0]};
        end else if (dmw1_hit) begin
            paddr = {dmw1_pseg, va[28:0]};
        end else begin
            paddr = tlb_paddr;
        end
    end

    // user mode may not touch the upper half
    assign adef = (va[1:0] != 2'b00) || (crmd_plv == PLV_USER && va[31]);

    always_comb begin
        if (adef) begin
            exc = EXC_ADEF;
        end else if (tlb_path && !s_found) begin
            exc = EXC_TLBR;
        end else if (tlb_path && !s_v) begin
            exc = EXC_PIF;
        end else if (tlb_path && crmd_plv > s_plv) begin
            exc = EXC_PPI;
        end else begin
            exc = EXC_NONE;
        end
    end

endmodule

/* mmu/itlb.sv */
`timescale 1ns/1ps

module itlb
    import fetch_pkg::*;
#(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input  logic [19:0]                    tlb_wvppn,
    input  logic [5:0]                     tlb_wps,
    input  logic [19:0]                    tlb_wppn,
    input  logic [1:0]                     tlb_wplv,
    input  logic                           tlb_wv,
    input  logic [19:0]                    s_va,
    output logic                           s_found,
    output logic [19:0]                    s_ppn,
    output logic [5:0]                     s_ps,
    output logic [1:0]                     s_plv,
    output logic                           s_v
);

    logic [TLB_ENTRIES-1:0] e_exist;
    logic [19:0]            e_vppn [TLB_ENTRIES];
    logic [5:0]             e_ps   [TLB_ENTRIES];
    logic [19:0]            e_ppn  [TLB_ENTRIES];
    logic [1:0]             e_plv  [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] e_v;
    logic [TLB_ENTRIES-1:0] hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            e_exist <= '0;
        end else if (tlb_we) begin
            e_exist[tlb_windex] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            e_vppn[tlb_windex] <= tlb_wvppn;
            e_ps[tlb_windex]   <= tlb_wps;
            e_ppn[tlb_windex]  <= tlb_wppn;
            e_plv[tlb_windex]  <= tlb_wplv;
            e_v[tlb_windex]    <= tlb_wv;
        end
    end

    // 4M pages only compare the top ten vppn bits
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (e_ps[i] == PAGE_SHIFT_4K) begin
                hit[i] = e_exist[i] && e_vppn[i] == s_va;
            end else begin
                hit[i] = e_exist[i] && e_vppn[i][19:10] == s_va[19:10];
            end
        end
    end

    // scan downward so the lowest index wins
    always_comb begin
        s_found = 1'b0;
        s_ppn   = '0;
        s_ps    = '0;
        s_plv   = '0;
        s_v     = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                s_found = 1'b1;
                s_ppn   = e_ppn[i];
                s_ps    = e_ps[i];
                s_plv   = e_plv[i];
                s_v     = e_v[i];
            end
        end
    end

endmodule

/* src/fetch_csr.sv */
`timescale 1ns/1ps

module fetch_csr
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        csr_we,
    input  csr_num_e    csr_num,
    input  logic [31:0] csr_wdata,
    output logic        crmd_da,
    output logic        crmd_pg,
    output logic [1:0]  crmd_plv,
    output logic        dmw0_plv0,
    output logic        dmw0_plv3,
    output logic        dmw1_plv0,
    output logic        dmw1_plv3,
    output logic [2:0]  dmw0_vseg,
    output logic [2:0]  dmw0_pseg,
    output logic [2:0]  dmw1_vseg,
    output logic [2:0]  dmw1_pseg
);

    // boot in direct address mode, kernel level, windows off
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_plv  <= PLV_KERNEL;
            dmw0_plv0 <= 1'b0;
            dmw0_plv3 <= 1'b0;
            dmw1_plv0 <= 1'b0;
            dmw1_plv3 <= 1'b0;
        end else if (csr_we) begin
            case (csr_num)
                CSR_CRMD: begin
                    crmd_da  <= csr_wdata[CRMD_DA];
                    crmd_pg  <= csr_wdata[CRMD_PG];
                    crmd_plv <= csr_wdata[CRMD_PLV_LSB +: 2];
                end
                CSR_DMW0: begin
                    dmw0_plv0 <= csr_wdata[DMW_PLV0];
                    dmw0_plv3 <= csr_wdata[DMW_PLV3];
                end
                CSR_DMW1: begin
                    dmw1_plv0 <= csr_wdata[DMW_PLV0];
                    dmw1_plv3 <= csr_wdata[DMW_PLV3];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (csr_we && csr_num == CSR_DMW0) begin
            dmw0_vseg <= csr_wdata[DMW_VSEG_LSB +: 3];
            dmw0_pseg <= csr_wdata[DMW_PSEG_LSB +: 3];
        end
        if (csr_we && csr_num == CSR_DMW1) begin
            dmw1_vseg <= csr_wdata[DMW_VSEG_LSB +: 3];
            dmw1_pseg <= csr_wdata[DMW_PSEG_LSB +: 3];
        end
    end

endmodule

/* common/fetch_pkg.sv */
package fetch_pkg;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ADEF,
        EXC_TLBR,
        EXC_PIF,
        EXC_PPI
    } fetch_exc_e;

    typedef enum logic [1:0] {
        CSR_CRMD,
        CSR_DMW0,
        CSR_DMW1
    } csr_num_e;

    // page size codes as held in an itlb entry
    localparam logic [5:0] PAGE_SHIFT_4K = 6'd12;
    localparam logic [5:0] PAGE_SHIFT_4M = 6'd22;

    localparam logic [1:0] PLV_KERNEL = 2'd0;
    localparam logic [1:0] PLV_USER   = 2'd3;

    // crmd layout
    localparam int CRMD_PLV_LSB = 0;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;

    // dmw layout, mat lives in 5:4
    localparam int DMW_PLV0     = 0;
    localparam int DMW_PLV3     = 3;
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_VSEG_LSB = 29;

endpackage
